//--- include/cpu_cfg.svh
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// Datapath widths
`define CPU_DATA_W 8
`define CPU_ADDR_W 16

// Scratchpad registers R0..RF
`define CPU_REG_CNT 16
`define CPU_REG_IDX_W 4

`endif

//--- source/acc_unit.sv
`timescale 1ns/1ns

module acc_unit import cpu_pkg::*; (
	input logic clk,
	input logic rst_n,
	dec_if.acc dec,
	input logic acc_go,
	input byte_t operand,
	input logic [3:0] ef,
	output byte_t d,
	output logic q,
	output logic branch_taken
);

	localparam int MSB = $bits(byte_t) - 1;

	logic df;
	logic cond_true;
	logic [MSB+1:0] sum;

	assign sum = d + operand;

	always_comb begin
		case (dec.cond)
			3'd0: cond_true = 1'b1;
			3'd1: cond_true = q;
			3'd2: cond_true = (d == '0);
			3'd3: cond_true = df;
			default: cond_true = ef[dec.cond[1:0]]; // EF1..EF4
		endcase
		branch_taken = (dec.kind == OP_BR) && (cond_true ^ dec.imm_inv);
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			d <= '0;
			df <= 1'b0;
			q <= 1'b0;
		end else if (acc_go) begin
			case (dec.kind)
				OP_LDN, OP_LDA, OP_GLO, OP_GHI: d <= operand;
				OP_REQ: q <= 1'b0;
				OP_SEQ: q <= 1'b1;
				OP_ALU, OP_SHIFT: begin
					case (dec.fn)
						FN_LOAD: d <= operand;
						FN_OR: d <= d | operand;
						FN_AND: d <= d & operand;
						FN_XOR: d <= d ^ operand;
						FN_ADD: {df, d} <= sum;
						FN_SD: begin
							d <= operand - d;
							df <= (operand >= d); // No borrow
						end
						FN_SM: begin
							d <= d - operand;
							df <= (d >= operand);
						end
						FN_SHIFT: begin
							if (dec.imm_inv) begin // SHL
								df <= d[MSB];
								d <= d << 1;
							end else begin
								df <= d[0];
								d <= d >> 1;
							end
						end
						default: ;
					endcase
				end
				default: ;
			endcase
		end
	end

endmodule

//--- source/cpu_pkg.sv
`include "cpu_cfg.svh"

package cpu_pkg;

	typedef logic [`CPU_DATA_W-1:0] byte_t;
	typedef logic [`CPU_ADDR_W-1:0] addr_t;
	typedef logic [`CPU_REG_IDX_W-1:0] reg_idx_t;

	// Low nibble is a register number or imm/invert bit plus a 3 bit code
	typedef union packed {
		struct packed {
			logic [3:0] op;
			reg_idx_t n;
		} reg_form;
		struct packed {
			logic [3:0] op;
			logic imm_inv;
			logic [2:0] code;
		} fn_form;
	} instr_u;

	typedef enum logic [4:0] {
		OP_NOP, OP_IDL, OP_LDN, OP_INC, OP_DEC, OP_BR, OP_LDA, OP_STR,
		OP_REQ, OP_SEQ, OP_GLO, OP_GHI, OP_PLO, OP_PHI, OP_SEP, OP_SEX,
		OP_ALU, OP_SHIFT
	} op_kind_e;

	// Order matches the F group low bits
	typedef enum logic [2:0] {
		FN_LOAD, FN_OR, FN_AND, FN_XOR, FN_ADD, FN_SD, FN_SHIFT, FN_SM
	} alu_fn_e;

	typedef enum logic [1:0] {WR_NONE, WR_LO, WR_HI, WR_BOTH} wr_lane_e;

endpackage

//--- source/cpu_sequencer.sv
`timescale 1ns/1ns

module cpu_sequencer import cpu_pkg::*; (
	input logic clk,
	input logic rst_n,
	dec_if.seq dec,
	output logic instr_load,
	output byte_t bus_byte,
	output reg_idx_t rd_idx,
	input addr_t rd_data,
	output reg_idx_t wr_idx,
	output wr_lane_e wr_lane,
	output addr_t wr_data,
	output logic acc_go,
	output byte_t operand,
	input byte_t d,
	input logic branch_taken,
	output logic mem_req,
	input logic mem_ack,
	output logic mem_we,
	output addr_t mem_addr,
	output byte_t mem_wdata,
	input byte_t mem_rdata,
	output logic idle
);

	typedef enum logic [2:0] {S_FETCH, S_EXEC, S_MEM, S_BRANCH, S_IDLE} state_e;

	state_e state;
	reg_idx_t x;
	reg_idx_t p;
	reg_idx_t mem_idx;
	logic bus_state;
	logic raise;
	logic done;

	assign bus_byte = mem_rdata; // Latched by the decoder

	// Immediate F ops read M(R(P)), the others M(R(X))
	assign mem_idx = (dec.kind == OP_ALU) ? (dec.imm_inv ? p : x) : dec.n;

	assign bus_state = (state == S_FETCH) || (state == S_MEM) || (state == S_BRANCH);
	assign raise = bus_state && !mem_req && !mem_ack; // Previous ack must be low
	assign done = mem_req && mem_ack;

	always_comb begin
		rd_idx = p;
		if (state == S_EXEC)
			rd_idx = (dec.kind == OP_BR) ? p : dec.n;
		else if (state == S_MEM)
			rd_idx = mem_idx;

		wr_idx = rd_idx;
		wr_data = rd_data + 1'b1;
		wr_lane = WR_NONE;
		acc_go = 1'b0;
		instr_load = 1'b0;
		operand = mem_rdata;

		case (state)
			S_FETCH: begin
				if (done) begin
					instr_load = 1'b1;
					wr_lane = WR_BOTH; // PC post-increment
				end
			end
			S_EXEC: begin
				case (dec.kind)
					OP_INC: wr_lane = WR_BOTH;
					OP_DEC: begin
						wr_data = rd_data - 1'b1;
						wr_lane = WR_BOTH;
					end
					OP_BR: wr_lane = branch_taken ? WR_NONE : WR_BOTH; // Skip target byte
					OP_PLO: begin
						wr_data = {d, d};
						wr_lane = WR_LO;
					end
					OP_PHI: begin
						wr_data = {d, d};
						wr_lane = WR_HI;
					end
					OP_GLO: begin
						operand = rd_data[7:0];
						acc_go = 1'b1;
					end
					OP_GHI: begin
						operand = rd_data[15:8];
						acc_go = 1'b1;
					end
					OP_REQ, OP_SEQ, OP_SHIFT: acc_go = 1'b1;
					default: ;
				endcase
			end
			S_MEM: begin
				if (done) begin
					acc_go = (dec.kind != OP_STR);
					if (dec.kind == OP_LDA || (dec.kind == OP_ALU && dec.imm_inv))
						wr_lane = WR_BOTH;
				end
			end
			S_BRANCH: begin
				if (done) begin
					wr_data = {mem_rdata, mem_rdata};
					wr_lane = WR_LO; // Same page jump
				end
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= S_FETCH;
			x <= '0;
			p <= '0;
			mem_req <= 1'b0;
			mem_we <= 1'b0;
			idle <= 1'b0;
		end else if (state == S_EXEC) begin
			state <= S_FETCH;
			case (dec.kind)
				OP_IDL: begin
					state <= S_IDLE;
					idle <= 1'b1;
				end
				OP_LDN, OP_LDA, OP_STR, OP_ALU: state <= S_MEM;
				OP_BR: if (branch_taken) state <= S_BRANCH;
				OP_SEP: p <= dec.n;
				OP_SEX: x <= dec.n;
				default: ;
			endcase
		end else if (raise) begin
			mem_req <= 1'b1;
			mem_we <= (state == S_MEM) && (dec.kind == OP_STR);
		end else if (done) begin
			mem_req <= 1'b0;
			mem_we <= 1'b0;
			state <= (state == S_FETCH) ? S_EXEC : S_FETCH;
		end
	end

	// Held for the whole request
	always_ff @(posedge clk) begin
		if (raise) begin
			mem_addr <= rd_data;
			mem_wdata <= d;
		end
	end

endmodule

//--- source/cpu_top.sv
`timescale 1ns/1ns

module cpu_top import cpu_pkg::*; (
	input logic clk,
	input logic rst_n,
	output logic mem_req,
	input logic mem_ack,
	output logic mem_we,
	output addr_t mem_addr,
	output byte_t mem_wdata,
	input byte_t mem_rdata,
	input logic [3:0] ef,
	output logic q,
	output logic idle
);

	dec_if u_dec_if ();

	logic instr_load;
	byte_t bus_byte;
	reg_idx_t rd_idx;
	addr_t rd_data;
	reg_idx_t wr_idx;
	wr_lane_e wr_lane;
	addr_t wr_data;
	logic acc_go;
	byte_t operand;
	byte_t d;
	logic branch_taken;

	instr_decoder u_decoder (
		.clk(clk), .rst_n(rst_n), .instr_load(instr_load), .fetch_byte(bus_byte),
		.dec(u_dec_if.decoder)
	);

	cpu_sequencer u_seq (
		.clk(clk), .rst_n(rst_n), .dec(u_dec_if.seq),
		.instr_load(instr_load), .bus_byte(bus_byte),
		.rd_idx(rd_idx), .rd_data(rd_data),
		.wr_idx(wr_idx), .wr_lane(wr_lane), .wr_data(wr_data),
		.acc_go(acc_go), .operand(operand), .d(d), .branch_taken(branch_taken),
		.mem_req(mem_req), .mem_ack(mem_ack), .mem_we(mem_we),
		.mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_rdata(mem_rdata),
		.idle(idle)
	);

	reg_file u_regs (
		.clk(clk), .rst_n(rst_n), .rd_idx(rd_idx), .rd_data(rd_data),
		.wr_idx(wr_idx), .wr_lane(wr_lane), .wr_data(wr_data)
	);

	acc_unit u_acc (
		.clk(clk), .rst_n(rst_n), .dec(u_dec_if.acc), .acc_go(acc_go),
		.operand(operand), .ef(ef), .d(d), .q(q), .branch_taken(branch_taken)
	);

endmodule

//--- source/dec_if.sv
`timescale 1ns/1ns

interface dec_if;

	cpu_pkg::op_kind_e kind;
	cpu_pkg::reg_idx_t n;
	cpu_pkg::alu_fn_e fn;
	logic imm_inv;
	logic [2:0] cond;
	cpu_pkg::instr_u instr; // Raw latched byte

	modport decoder (
		output kind, n, fn, imm_inv, cond, instr
	);

	modport seq (input kind, n, imm_inv);

	modport acc (input kind, fn, imm_inv, cond);

endinterface

//--- source/instr_decoder.sv
`timescale 1ns/1ns

module instr_decoder import cpu_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic instr_load,
	input byte_t fetch_byte,
	dec_if.decoder dec
);

	instr_u instr;

	always_ff @(posedge clk) begin
		if (!rst_n)
			instr <= '0;
		else if (instr_load)
			instr <= instr_u'(fetch_byte);
	end

	always_comb begin
		dec.instr = instr;
		dec.n = instr.reg_form.n;
		dec.imm_inv = instr.fn_form.imm_inv;
		dec.cond = instr.fn_form.code;
		dec.fn = alu_fn_e'(instr.fn_form.code); // F0 and F8 land on load

		case (instr.reg_form.op)
			4'h0: dec.kind = (instr.reg_form.n == '0) ? OP_IDL : OP_LDN;
			4'h1: dec.kind = OP_INC;
			4'h2: dec.kind = OP_DEC;
			4'h3: dec.kind = OP_BR;
			4'h4: dec.kind = OP_LDA;
			4'h5: dec.kind = OP_STR;
			4'h7: begin
				case (instr.reg_form.n)
					4'hA: dec.kind = OP_REQ;
					4'hB: dec.kind = OP_SEQ;
					default: dec.kind = OP_NOP; // Group 7 arithmetic not kept
				endcase
			end
			4'h8: dec.kind = OP_GLO;
			4'h9: dec.kind = OP_GHI;
			4'hA: dec.kind = OP_PLO;
			4'hB: dec.kind = OP_PHI;
			4'hD: dec.kind = OP_SEP;
			4'hE: dec.kind = OP_SEX;
			4'hF: begin
				if (alu_fn_e'(instr.fn_form.code) == FN_SHIFT)
					dec.kind = OP_SHIFT; // No operand fetch
				else
					dec.kind = OP_ALU;
			end
			default: dec.kind = OP_NOP; // IO group and long branches
		endcase
	end

endmodule

//--- source/reg_file.sv
`timescale 1ns/1ns
`include "cpu_cfg.svh"

module reg_file import cpu_pkg::*; (
	input logic clk,
	input logic rst_n,
	input reg_idx_t rd_idx,
	output addr_t rd_data,
	input reg_idx_t wr_idx,
	input wr_lane_e wr_lane,
	input addr_t wr_data
);

	addr_t regs [`CPU_REG_CNT];

	assign rd_data = regs[rd_idx];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < `CPU_REG_CNT; i++)
				regs[i] <= '0;
		end else begin
			case (wr_lane)
				WR_LO:
					regs[wr_idx][`CPU_DATA_W-1:0] <= wr_data[`CPU_DATA_W-1:0];
				WR_HI: begin
					regs[wr_idx][`CPU_ADDR_W-1:`CPU_DATA_W] <=
						wr_data[`CPU_ADDR_W-1:`CPU_DATA_W];
				end
				WR_BOTH:
					regs[wr_idx] <= wr_data;
				default: ;
			endcase
		end
	end

endmodule

//--- tb.f
+incdir+include
source/cpu_pkg.sv
source/dec_if.sv
source/instr_decoder.sv
source/reg_file.sv
source/cpu_sequencer.sv
source/acc_unit.sv
source/cpu_top.sv
tb/mem_model.sv
tb/cpu_tb.sv

//--- tb/cpu_tb.sv
`timescale 1ns/1ns

module cpu_tb import cpu_pkg::*; ();

	// 6 tests, 40 handshakes, 12 cycles each, plus resets and the idle watch, doubled
	localparam int TIMEOUT_CYCLES = 2 * (6 * 40 * 12 + 6 * 8 + 50);

	logic clk;
	logic rst_n;
	logic mem_req;
	logic mem_ack;
	logic mem_we;
	addr_t mem_addr;
	byte_t mem_wdata;
	byte_t mem_rdata;
	logic [3:0] ef;
	logic q;
	logic idle;

	int errors = 0;
	int err_mark = 0;
	int pass_cnt = 0;
	int fail_cnt = 0;
	int cycles = 0;
	int unsigned seed = 32'h367c4584;
	int unsigned first_draw;
	byte_t prog [$];
	byte_t chunk [$];
	addr_t exp_addr [$];
	byte_t exp_data [$];

	logic req_prev = 1'b0;
	logic ack_prev = 1'b0;
	addr_t addr_prev;
	logic we_prev;
	byte_t wdata_prev;

	cpu_top u_dut (
		.clk(clk), .rst_n(rst_n), .mem_req(mem_req), .mem_ack(mem_ack), .mem_we(mem_we),
		.mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_rdata(mem_rdata),
		.ef(ef), .q(q), .idle(idle)
	);

	mem_model u_mem (
		.clk(clk), .mem_req(mem_req), .mem_we(mem_we), .mem_addr(mem_addr),
		.mem_wdata(mem_wdata), .mem_ack(mem_ack), .mem_rdata(mem_rdata)
	);

	always #20 clk = ~clk;

	initial begin
		while (cycles < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout: the core did not finish all programs within %0d cycles", cycles);
		$display("test failed");
		$finish;
	end

	// Four-phase rules, sampled away from the edges
	always @(negedge clk) begin
		if (mem_req && req_prev) begin
			if (mem_addr !== addr_prev || mem_we !== we_prev || mem_wdata !== wdata_prev) begin
				$display("At %0t the bus address, direction or write data moved during a request",
					$time);
				errors++;
			end
		end else if (mem_req && ack_prev) begin
			$display("At %0t a new request started before mem_ack had fallen", $time);
			errors++;
		end
		req_prev = mem_req;
		ack_prev = mem_ack;
		addr_prev = mem_addr;
		we_prev = mem_we;
		wdata_prev = mem_wdata;
	end

	task automatic check_byte(input string sig, input byte_t exp, input byte_t act);
		if (act !== exp) begin
			$display("MISMATCH t=%0t %s expected %h actual %h", $time, sig, exp, act);
			errors++;
		end
	endtask

	task automatic check_addr(input string sig, input addr_t exp, input addr_t act);
		if (act !== exp) begin
			$display("MISMATCH t=%0t %s expected %h actual %h", $time, sig, exp, act);
			errors++;
		end
	endtask

	task automatic check_bit(input string sig, input logic exp, input logic act);
		if (act !== exp) begin
			$display("MISMATCH t=%0t %s expected %b actual %b", $time, sig, exp, act);
			errors++;
		end
	endtask

	task automatic check_count(input string sig, input int exp, input int act);
		if (act != exp) begin
			$display("MISMATCH t=%0t %s expected %0d actual %0d", $time, sig, exp, act);
			errors++;
		end
	endtask

	task automatic start_case();
		err_mark = errors;
		prog.delete();
		exp_addr.delete();
		exp_data.delete();
	endtask

	task automatic want_write(input addr_t a, input byte_t v);
		exp_addr.push_back(a);
		exp_data.push_back(v);
	endtask

	// Pads with IDL up to addr, then appends chunk
	task automatic place_chunk(input int addr);
		while (prog.size() < addr)
			prog.push_back(8'h00);
		for (int i = 0; i < chunk.size(); i++)
			prog.push_back(chunk[i]);
	endtask

	task automatic execute_program(input logic [3:0] ef_val, input int max_delay);
		@(posedge clk);
		#2;
		rst_n = 1'b0;
		ef = ef_val;
		u_mem.clear();
		for (int i = 0; i < prog.size(); i++)
			u_mem.mem[i] = prog[i];
		for (int i = 0; i < 200 && max_delay > 0; i++)
			u_mem.delays.push_back($urandom_range(max_delay, 0));
		repeat (8) @(posedge clk);
		#2;
		rst_n = 1'b1;
		do
			@(negedge clk);
		while (!idle);
	endtask

	task automatic finish_case(input string name);
		check_count("write count", exp_addr.size(), u_mem.log_addr.size());
		for (int i = 0; i < exp_addr.size() && i < u_mem.log_addr.size(); i++) begin
			check_addr($sformatf("write %0d mem_addr", i), exp_addr[i], u_mem.log_addr[i]);
			check_byte($sformatf("write %0d mem_wdata", i), exp_data[i], u_mem.log_data[i]);
		end
		if (errors == err_mark) begin
			pass_cnt++;
			$display("%s: ok", name);
		end else begin
			fail_cnt++;
			$display("%s: FAILED", name);
		end
	endtask

	task automatic transfer_regs(input string name, input int max_delay);
		start_case();
		prog = '{8'hF8, 8'h01, 8'hB2, 8'hF8, 8'h10, 8'hA2, 8'hF8, 8'h5A, 8'h52, 8'h12,
			8'hF8, 8'h34, 8'hA3, 8'hF8, 8'h12, 8'hB3, 8'h13, 8'h23, 8'h23,
			8'h83, 8'h52, 8'h12, 8'h93, 8'h52, 8'h12, 8'h24, 8'h84, 8'h52, 8'h00};
		want_write(16'h0110, 8'h5A);
		want_write(16'h0111, 8'h33); // R3 = 1234 + 1 - 2
		want_write(16'h0112, 8'h12);
		want_write(16'h0113, 8'hFF); // R4 wraps to FFFF
		execute_program(4'h0, max_delay);
		finish_case(name);
	endtask

	task automatic alu_immediate();
		start_case();
		prog = '{8'hF8, 8'h01, 8'hB2, 8'hF8, 8'hF0, 8'hF9, 8'h0F, 8'hFA, 8'h3C,
			8'hFB, 8'hFF, 8'h52, 8'h12, 8'hFC, 8'h50, 8'h52, 8'h12, 8'h3B, 8'h14, 8'h7B,
			8'hFD, 8'h10, 8'h52, 8'h12, 8'h3B, 8'h1B, 8'h7A,
			8'hFF, 8'h0D, 8'h52, 8'h12, 8'h33, 8'h22, 8'h7A,
			8'hFE, 8'h52, 8'h12, 8'h33, 8'h28, 8'h7A,
			8'hFF, 8'hF0, 8'h52, 8'h12, 8'h3B, 8'h2F, 8'h7A, 8'h00};
		want_write(16'h0100, 8'hC3); // ((F0 | 0F) & 3C) ^ FF
		want_write(16'h0101, 8'h13); // C3 + 50, carry out
		want_write(16'h0102, 8'hFD); // 10 - 13, borrow
		want_write(16'h0103, 8'hF0);
		want_write(16'h0104, 8'hE0);
		want_write(16'h0105, 8'hF0); // E0 - F0, borrow
		execute_program(4'h0, 0);
		check_bit("q", 1'b1, q); // Set after ADI and cleared by any wrong DF
		finish_case("alu immediate");
	endtask

	task automatic memory_forms();
		start_case();
		prog = '{8'hF8, 8'h80, 8'hA5, 8'hF8, 8'h01, 8'hB2, 8'h45, 8'h52, 8'h12,
			8'h45, 8'h52, 8'h12, 8'h85, 8'h52, 8'h12, 8'hE5, 8'hF0, 8'h52, 8'h12,
			8'hF8, 8'h44, 8'hF1, 8'h52, 8'h12, 8'hF2, 8'h52, 8'h12, 8'hF4, 8'h52, 8'h12,
			8'hF5, 8'h52, 8'h12, 8'hF7, 8'h52, 8'h12, 8'hF6, 8'h52, 8'h12,
			8'h15, 8'h05, 8'h52, 8'h00};
		chunk = '{8'h11, 8'h22, 8'h33, 8'h0F};
		place_chunk(8'h80); // Table walked through R5
		want_write(16'h0100, 8'h11);
		want_write(16'h0101, 8'h22);
		want_write(16'h0102, 8'h82); // R5 after two LDA
		want_write(16'h0103, 8'h33);
		want_write(16'h0104, 8'h77);
		want_write(16'h0105, 8'h33);
		want_write(16'h0106, 8'h66);
		want_write(16'h0107, 8'hCD); // 33 - 66
		want_write(16'h0108, 8'h9A); // CD - 33
		want_write(16'h0109, 8'h4D);
		want_write(16'h010A, 8'h0F);
		execute_program(4'h0, 0);
		finish_case("memory forms");
	endtask

	task automatic short_branches();
		byte_t ops [$];
		bit taken [$];
		int at;
		start_case();
		ops = '{8'h30, 8'h38, 8'h31, 8'h39, 8'h32, 8'h3A, 8'h33, 8'h3B,
			8'h34, 8'h35, 8'h36, 8'h37, 8'h3C, 8'h3D, 8'h3E, 8'h3F,
			8'h31, 8'h39, 8'h32, 8'h3A, 8'h33, 8'h3B};
		// First 16 with D=01, DF=0, Q=0, EF1 and EF3 high; last 6 with D=00, DF=1, Q=1
		taken = '{1, 0, 0, 1, 0, 1, 0, 1, 1, 0, 1, 0, 0, 1, 0, 1, 1, 0, 1, 0, 1, 0};
		prog = '{8'hF8, 8'h01, 8'hB2};
		for (int k = 0; k < ops.size(); k++) begin
			if (k == 16) begin
				chunk = '{8'h7B, 8'hF8, 8'hFF, 8'hFC, 8'h01}; // SEQ, FF + 01
				place_chunk(prog.size());
			end
			at = prog.size();
			prog.push_back(ops[k]);
			prog.push_back(byte_t'(at + 3)); // INC R2
			prog.push_back(8'h52);
			prog.push_back(8'h12);
			if (!taken[k])
				want_write(addr_t'(16'h0100 + k), (k < 16) ? 8'h01 : 8'h00);
		end
		prog.push_back(8'h00);
		execute_program(4'b0101, 0);
		finish_case("short branches");
	endtask

	task automatic sep_and_idle();
		logic req_seen;
		req_seen = 1'b0;
		start_case();
		// Falling through SEP would store EE at 0000
		prog = '{8'hF8, 8'h40, 8'hA3, 8'hD3, 8'hF8, 8'hEE, 8'h52, 8'h00};
		chunk = '{8'hF8, 8'h01, 8'hB2, 8'hF8, 8'hA5, 8'h52, 8'h00};
		place_chunk(8'h40);
		want_write(16'h0100, 8'hA5);
		execute_program(4'h0, 0);
		repeat (50) begin
			@(negedge clk);
			if (mem_req !== 1'b0)
				req_seen = 1'b1;
		end
		check_bit("idle", 1'b1, idle);
		check_bit("mem_req after IDL", 1'b0, req_seen);
		finish_case("sep and idle");
	endtask

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		ef = 4'h0;
		first_draw = $urandom(seed);
		transfer_regs("register transfer", 0);
		alu_immediate();
		memory_forms();
		short_branches();
		sep_and_idle();
		transfer_regs("back-pressure", 8);
		$display("Summary: %0d passing, %0d failing", pass_cnt, fail_cnt);
		if (fail_cnt == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

//--- tb/mem_model.sv
`timescale 1ns/1ns
`include "cpu_cfg.svh"

module mem_model import cpu_pkg::*; (
	input logic clk,
	input logic mem_req,
	input logic mem_we,
	input addr_t mem_addr,
	input byte_t mem_wdata,
	output logic mem_ack,
	output byte_t mem_rdata
);

	byte_t mem [1 << `CPU_ADDR_W];
	addr_t log_addr [$];
	byte_t log_data [$];
	int delays [$]; // Ack rise and fall delays in turn
	int wait_left;

	initial begin
		mem_ack = 1'b0;
		mem_rdata = '0;
		wait_left = -1;
	end

	task automatic clear();
		for (int i = 0; i < (1 << `CPU_ADDR_W); i++)
			mem[i] = '0; // 00 is IDL
		log_addr.delete();
		log_data.delete();
		delays.delete();
		wait_left = -1;
	endtask

	always @(posedge clk) begin
		#2;
		if (mem_req && !mem_ack) begin
			if (wait_left < 0)
				wait_left = (delays.size() > 0) ? delays.pop_front() : 0;
			if (wait_left > 0) begin
				wait_left--;
			end else begin
				if (mem_we) begin
					mem[mem_addr] = mem_wdata;
					log_addr.push_back(mem_addr);
					log_data.push_back(mem_wdata);
				end else begin
					mem_rdata = mem[mem_addr];
				end
				mem_ack = 1'b1;
				wait_left = -1;
			end
		end else if (!mem_req && mem_ack) begin
			if (wait_left < 0)
				wait_left = (delays.size() > 0) ? delays.pop_front() : 0;
			if (wait_left > 0) begin
				wait_left--; // Late release
			end else begin
				mem_ack = 1'b0; // Last phase
				wait_left = -1;
			end
		end
	end

endmodule
